/* logic/vec_bus_pkg.sv */
package vec_bus_pkg;

	// ------------------------------
	// CPU bus
	// ------------------------------

	// Generic 8080-style bus as seen from the core
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        sync;
		logic        rd;
		logic        wr_n;
	} cpu_bus_t;

	// Status byte put on the data bus during sync
	typedef struct packed {
		logic ram_read;
		logic io_read;
		logic m1;
		logic io_write;
		logic halt_ack;
		logic io_stack;
		logic write_n;
		logic int_ack;
	} status_word_t;

	// Strobes decoded from the status byte and rd / wr_n
	typedef struct packed {
		logic mreq;
		logic io_rd;
		logic io_wr;
		logic stack;
		logic int_ack;
		logic ram_read;
		logic mem_write;
	} cycle_t;

	// ------------------------------
	// I/O side
	// ------------------------------

	typedef struct packed {
		logic joy_sel;
		logic pal_sel;
		logic edsk_sel;
	} io_sel_t;

	// Single-bit command written to port 04h
	typedef struct packed {
		logic       is_mode;
		logic [2:0] unused;
		logic [2:0] bit_index;
		logic       bit_value;
	} joy_bit_cmd_t;

	// Port 05h takes the whole byte, port 04h the bit command
	typedef union packed {
		logic [7:0]   whole;
		joy_bit_cmd_t bit_cmd;
	} joy_wr_u;

endpackage

/* logic/vec_map_pkg.sv */
package vec_map_pkg;

	// ------------------------------
	// Port map
	// ------------------------------

	// Value seen on a port nobody drives
	localparam logic [7:0] IO_IDLE = 8'hFF;

	// Joystick register, 04h for bit commands and 05h for whole byte
	localparam logic [7:0] PORT_JOY_CTRL = 8'h04;

	// Joystick reads
	localparam logic [7:0] PORT_JOY_P  = 8'h06;
	localparam logic [7:0] PORT_JOY_PU = 8'h07;
	localparam logic [7:0] PORT_JOY_A  = 8'h0E;
	localparam logic [7:0] PORT_JOY_B  = 8'h0F;

	// E-disk control
	localparam logic [7:0] PORT_EDSK = 8'h10;

	// ------------------------------
	// RAM pages
	// ------------------------------

	// Main RAM, E-disk banks follow at 1..4
	localparam logic [2:0] PAGE_BASE = 3'd0;

	// ------------------------------
	// Host joystick vector
	// ------------------------------

	localparam logic [2:0] JOY_RIGHT_BIT = 3'd0;
	localparam logic [2:0] JOY_LEFT_BIT  = 3'd1;
	localparam logic [2:0] JOY_DOWN_BIT  = 3'd2;
	localparam logic [2:0] JOY_UP_BIT    = 3'd3;
	localparam logic [2:0] JOY_FIRE1_BIT = 3'd4;
	localparam logic [2:0] JOY_FIRE2_BIT = 3'd5;

endpackage

/* logic/bus_status_latch.sv */
module bus_status_latch
	import vec_bus_pkg::*;
(
	input  logic         clk_sys,
	input  logic         cold_reset,
	input  cpu_bus_t     bus_i,
	output status_word_t status_o,
	output cycle_t       cycle_o
);

	logic         sync_q;
	status_word_t status_q;

	// Status byte is valid on dout at the rising edge of sync
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q   <= 1'b0;
			status_q <= '0;
		end else begin
			sync_q <= bus_i.sync;
			if (!sync_q && bus_i.sync) begin
				status_q <= status_word_t'(bus_i.dout);
			end
		end
	end

	assign status_o = status_q;

	// ------------------------------
	// Cycle strobes
	// ------------------------------

	always_comb begin
		cycle_o.mreq      = (status_q.ram_read | ~status_q.write_n) &
		                    ~status_q.io_write & ~status_q.io_read;
		cycle_o.io_rd     = status_q.io_read & bus_i.rd;
		cycle_o.io_wr     = status_q.io_write & ~bus_i.wr_n;
		cycle_o.stack     = status_q.io_stack;
		cycle_o.int_ack   = status_q.int_ack;
		cycle_o.ram_read  = status_q.ram_read;
		// Memory write is any write that is not an OUT
		cycle_o.mem_write = ~bus_i.wr_n & ~status_q.io_write;
	end

	// An I/O cycle is either IN or OUT, never both
	a_io_dir_exclusive: assert property (
		@(posedge clk_sys) disable iff (cold_reset)
		!(status_q.io_read && status_q.io_write)
	);

	// Read and write strobes never overlap
	a_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (cold_reset)
		!(bus_i.rd && !bus_i.wr_n)
	);

endmodule

/* logic/io_port_decoder.sv */
module io_port_decoder
	import vec_bus_pkg::*;
	import vec_map_pkg::*;
(
	input  logic [7:0] port_i,
	input  logic [7:0] joy_p_i,
	input  logic [7:0] joy_pu_i,
	input  logic [7:0] joy_a_i,
	input  logic [7:0] joy_b_i,
	output io_sel_t    sel_o,
	output logic [7:0] io_data_o
);

	// Only the low address byte takes part in port decoding.
	// PPI, timer, sound and floppy ranges fall through to idle
	always_comb begin
		sel_o     = '0;
		io_data_o = IO_IDLE;

		if (port_i[7:1] == PORT_JOY_CTRL[7:1]) begin
			// Write-only register pair
			sel_o.joy_sel = 1'b1;
			io_data_o     = 8'h00;
		end else if (port_i == PORT_JOY_P) begin
			io_data_o = joy_p_i;
		end else if (port_i == PORT_JOY_PU) begin
			io_data_o = joy_pu_i;
		end else if (port_i[7:2] == PORT_JOY_A[7:2]) begin
			// Palette block 0Ch..0Fh, the top two also carry stick reads
			sel_o.pal_sel = 1'b1;
			if (port_i == PORT_JOY_A) begin
				io_data_o = joy_a_i;
			end else if (port_i == PORT_JOY_B) begin
				io_data_o = joy_b_i;
			end
		end else if (port_i == PORT_EDSK) begin
			sel_o.edsk_sel = 1'b1;
		end
	end

endmodule

/* logic/edisk_ctrl_reg.sv */
module edisk_ctrl_reg
	import vec_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       cold_reset,
	input  io_sel_t    sel_i,
	input  logic       io_wr_i,
	input  logic [7:0] data_i,
	output logic [7:0] ed_reg_o
);

	logic we;
	logic we_q;

	assign we = io_wr_i & sel_i.edsk_sel;

	// ------------------------------
	// Control byte
	// ------------------------------

	// bit 7,6  window over E000 / 8000
	// bit 5    window enable
	// bit 4    stack enable
	// bit 3:2  stack bank
	// bit 1:0  window bank
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			we_q     <= 1'b0;
			ed_reg_o <= 8'h00;
		end else begin
			we_q <= we;
			// Store once per OUT, however long wr_n stays low
			if (we && !we_q) begin
				ed_reg_o <= data_i;
			end
		end
	end

endmodule

/* logic/edisk_page_mapper.sv */
module edisk_page_mapper
	import vec_bus_pkg::*;
	import vec_map_pkg::*;
(
	input  logic [7:0]   ed_reg_i,
	input  logic [15:0]  addr_i,
	input  status_word_t status_i,
	output logic [2:0]   page_o
);

	logic win;
	logic mem_cyc;
	logic map_stack;
	logic map_win;

	// A000..DFFF always, E000 and 8000 blocks on request
	assign win = addr_i[15] & (
	             (addr_i[14] ^ addr_i[13]) |
	             (ed_reg_i[7] & addr_i[14] & addr_i[13]) |
	             (ed_reg_i[6] & ~addr_i[14] & ~addr_i[13]));

	assign mem_cyc = status_i.ram_read | ~status_i.write_n;

	assign map_stack = ed_reg_i[4] & status_i.io_stack & mem_cyc;
	assign map_win   = ed_reg_i[5] & win & mem_cyc;

	// Stack mapping wins
	always_comb begin
		if (map_stack) begin
			page_o = PAGE_BASE + 3'd1 + {1'b0, ed_reg_i[3:2]};
		end else if (map_win) begin
			page_o = PAGE_BASE + 3'd1 + {1'b0, ed_reg_i[1:0]};
		end else begin
			page_o = PAGE_BASE;
		end
	end

endmodule

/* logic/joystick_ports.sv */
module joystick_ports
	import vec_bus_pkg::*;
	import vec_map_pkg::*;
(
	input  logic       clk_sys,
	input  logic       cold_reset,
	input  io_sel_t    sel_i,
	input  logic       io_wr_i,
	input  logic       addr0_i,
	input  joy_wr_u    wr_data_i,
	input  logic [7:0] joy_a_i,
	input  logic [7:0] joy_b_i,
	output logic [7:0] joy_p_o,
	output logic [7:0] joy_pu_o,
	output logic [7:0] joy_a_o,
	output logic [7:0] joy_b_o
);

	logic       we;
	logic       we_q;
	logic [7:0] joy_port;
	logic [7:0] joy_or;

	// Stick seen by the machine, low active
	function automatic logic [7:0] stick_view(input logic [7:0] j);
		return ~{j[JOY_FIRE2_BIT], j[JOY_FIRE1_BIT], 2'b00,
		         j[JOY_DOWN_BIT], j[JOY_UP_BIT], j[JOY_LEFT_BIT], j[JOY_RIGHT_BIT]};
	endfunction

	// ------------------------------
	// Port register
	// ------------------------------

	assign we = io_wr_i & sel_i.joy_sel;

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			we_q     <= 1'b0;
			joy_port <= 8'h00;
		end else begin
			we_q <= we;
			if (we && !we_q) begin
				if (addr0_i) begin
					joy_port <= wr_data_i.whole;
				end else if (!wr_data_i.bit_cmd.is_mode) begin
					// Mode writes to 04h are ignored
					joy_port[wr_data_i.bit_cmd.bit_index] <= wr_data_i.bit_cmd.bit_value;
				end
			end
		end
	end

	// ------------------------------
	// Read views
	// ------------------------------

	assign joy_a_o = stick_view(joy_a_i);
	assign joy_b_o = stick_view(joy_b_i);

	// Either stick, high active
	assign joy_or   = joy_a_i | joy_b_i;
	assign joy_pu_o = {joy_or[JOY_UP_BIT], joy_or[JOY_RIGHT_BIT],
	                   joy_or[JOY_DOWN_BIT], joy_or[JOY_LEFT_BIT],
	                   joy_or[JOY_FIRE1_BIT], joy_or[JOY_FIRE2_BIT], 2'b00};

	// Source of port 06h
	always_comb begin
		case (joy_port[6:5])
			2'b00:   joy_p_o = joy_a_o & joy_b_o;
			2'b01:   joy_p_o = joy_a_o;
			2'b10:   joy_p_o = joy_b_o;
			default: joy_p_o = 8'hFF;
		endcase
	end

endmodule

/* logic/vec_io_top.sv */
module vec_io_top
	import vec_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       cold_reset,
	input  cpu_bus_t   cpu_bus_i,
	input  logic [7:0] joy_a_i,
	input  logic [7:0] joy_b_i,
	input  logic [7:0] mem_data_i,
	output logic [7:0] cpu_din_o,
	output logic       mem_req_o,
	output logic       mem_we_o,
	output logic [2:0] ram_page_o
);

	status_word_t status;
	cycle_t       cycle;
	io_sel_t      io_sel;
	joy_wr_u      joy_wr;
	logic [7:0]   io_rd_data;
	logic [7:0]   ed_reg;
	logic [7:0]   joy_p;
	logic [7:0]   joy_pu;
	logic [7:0]   joy_a_view;
	logic [7:0]   joy_b_view;

	bus_status_latch u_status (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.bus_i      (cpu_bus_i),
		.status_o   (status),
		.cycle_o    (cycle)
	);

	io_port_decoder u_decoder (
		.port_i    (cpu_bus_i.addr[7:0]),
		.joy_p_i   (joy_p),
		.joy_pu_i  (joy_pu),
		.joy_a_i   (joy_a_view),
		.joy_b_i   (joy_b_view),
		.sel_o     (io_sel),
		.io_data_o (io_rd_data)
	);

	// ------------------------------
	// E-disk
	// ------------------------------

	edisk_ctrl_reg u_ed_reg (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.sel_i      (io_sel),
		.io_wr_i    (cycle.io_wr),
		.data_i     (cpu_bus_i.dout),
		.ed_reg_o   (ed_reg)
	);

	edisk_page_mapper u_mapper (
		.ed_reg_i (ed_reg),
		.addr_i   (cpu_bus_i.addr),
		.status_i (status),
		.page_o   (ram_page_o)
	);

	// ------------------------------
	// Joysticks
	// ------------------------------

	assign joy_wr = joy_wr_u'(cpu_bus_i.dout);

	joystick_ports u_joy (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.sel_i      (io_sel),
		.io_wr_i    (cycle.io_wr),
		.addr0_i    (cpu_bus_i.addr[0]),
		.wr_data_i  (joy_wr),
		.joy_a_i    (joy_a_i),
		.joy_b_i    (joy_b_i),
		.joy_p_o    (joy_p),
		.joy_pu_o   (joy_pu),
		.joy_a_o    (joy_a_view),
		.joy_b_o    (joy_b_view)
	);

	// ------------------------------
	// CPU read data
	// ------------------------------

	always_comb begin
		if (cycle.int_ack) begin
			// RST 7 on interrupt acknowledge
			cpu_din_o = 8'hFF;
		end else if (status.io_read) begin
			cpu_din_o = io_rd_data;
		end else begin
			cpu_din_o = mem_data_i;
		end
	end

	assign mem_req_o = cycle.mreq;
	assign mem_we_o  = cycle.mem_write;

endmodule

/* bench/vec_io_model.sv */
package vec_io_model;

	// Status byte bits, 7 ram_read, 6 io_read, 4 io_write, 2 stack, 1 write_n, 0 int_ack

	// Stick as the machine reads it, low active
	function automatic logic [7:0] stick_byte(input logic [7:0] j);
		return ~{j[5], j[4], 2'b00, j[2], j[3], j[1], j[0]};
	endfunction

	function automatic logic [7:0] port_byte(input logic [7:0] port, input logic [7:0] joy_q,
	                                         input logic [7:0] a, input logic [7:0] b);
		logic [7:0] o;
		logic [7:0] r;
		o = a | b;
		case (port)
			8'h04, 8'h05: r = 8'h00;
			8'h06: begin
				case (joy_q[6:5])
					2'b00:   r = stick_byte(a) & stick_byte(b);
					2'b01:   r = stick_byte(a);
					2'b10:   r = stick_byte(b);
					default: r = 8'hFF;
				endcase
			end
			// up, right, down, left, fire1, fire2 of either stick
			8'h07:   r = {o[3], o[0], o[2], o[1], o[4], o[5], 2'b00};
			8'h0E:   r = stick_byte(a);
			8'h0F:   r = stick_byte(b);
			default: r = 8'hFF;
		endcase
		return r;
	endfunction

	function automatic logic [2:0] page_of(input logic [7:0] ed, input logic [15:0] addr,
	                                       input logic [7:0] st);
		logic win;
		logic mem;
		case (addr[15:13])
			3'b101, 3'b110: win = 1'b1;
			3'b111:         win = ed[7];
			3'b100:         win = ed[6];
			default:        win = 1'b0;
		endcase
		mem = st[7] | ~st[1];
		if (ed[4] && st[2] && mem) begin
			return 3'd1 + {1'b0, ed[3:2]};
		end else if (ed[5] && win && mem) begin
			return 3'd1 + {1'b0, ed[1:0]};
		end
		return 3'd0;
	endfunction

	// Port 05h loads the byte, 04h sets one bit unless it is a mode write
	function automatic logic [7:0] joy_after(input logic [7:0] joy_q, input logic addr0,
	                                         input logic [7:0] data);
		logic [7:0] r;
		r = joy_q;
		if (addr0) begin
			r = data;
		end else if (!data[7]) begin
			r[data[3:1]] = data[0];
		end
		return r;
	endfunction

	function automatic logic mreq_of(input logic [7:0] st);
		return (st[7] | ~st[1]) & ~st[4] & ~st[6];
	endfunction

	function automatic logic [7:0] din_of(input logic [7:0] st, input logic [7:0] io_byte,
	                                      input logic [7:0] mem);
		return st[0] ? 8'hFF : (st[6] ? io_byte : mem);
	endfunction

endpackage

/* bench/vec_io_tb.sv */
module vec_io_tb
	import vec_bus_pkg::*;
	import vec_io_model::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic       clk_sys;
	logic       cold_reset;
	cpu_bus_t   bus;
	logic [7:0] joy_a;
	logic [7:0] joy_b;
	logic [7:0] mem_data;
	logic [7:0] cpu_din;
	logic       mem_req;
	logic       mem_we;
	logic [2:0] page;

	// Model state
	logic [7:0] m_status = 8'h00;
	logic [7:0] m_ed = 8'h00;
	logic [7:0] m_joy = 8'h00;
	integer     seed = 32'h56b0;
	int         checks = 0;
	int         errors = 0;
	int         t_checks = 0;
	int         t_errors = 0;

	vec_io_top i_dut (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.cpu_bus_i  (bus),
		.joy_a_i    (joy_a),
		.joy_b_i    (joy_b),
		.mem_data_i (mem_data),
		.cpu_din_o  (cpu_din),
		.mem_req_o  (mem_req),
		.mem_we_o   (mem_we),
		.ram_page_o (page)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ------------------------------
	// Helpers
	// ------------------------------

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Read, stack read, write or stack write, picked at random
	function automatic logic [7:0] mem_status();
		logic [7:0] r;
		r = rand_byte();
		return {~r[1], 4'b0000, r[0], ~r[1], 1'b0};
	endfunction

	task automatic end_test(input string name);
		$display("test %-16s %0d checks, %0d mismatches", name, checks - t_checks,
		         errors - t_errors);
		t_checks = checks;
		t_errors = errors;
	endtask

	// Sync pulse carrying the status byte
	task automatic start_cycle(input logic [7:0] st, input logic [15:0] addr);
		@(posedge clk_sys);
		bus.sync <= 1'b1;
		bus.dout <= st;
		bus.addr <= addr;
		mem_data <= rand_byte();
		@(posedge clk_sys);
		bus.sync <= 1'b0;
		m_status = st;
	endtask

	task automatic bus_cycle(input logic [7:0] st, input logic [15:0] addr);
		logic wr;
		wr = ~st[1];
		start_cycle(st, addr);
		@(posedge clk_sys);
		if (wr) begin
			bus.wr_n <= 1'b0;
		end else begin
			bus.rd <= 1'b1;
		end
		@(negedge clk_sys);
		check("ram_page_o", {5'b0, page}, {5'b0, page_of(m_ed, addr, m_status)});
		check("mem_req_o", {7'b0, mem_req}, {7'b0, mreq_of(m_status)});
		check("mem_we_o", {7'b0, mem_we}, {7'b0, wr & ~m_status[4]});
		if (!wr) begin
			check("cpu_din_o", cpu_din,
			      din_of(m_status, port_byte(addr[7:0], m_joy, joy_a, joy_b), mem_data));
		end
		@(posedge clk_sys);
		bus.rd   <= 1'b0;
		bus.wr_n <= 1'b1;
	endtask

	// OUT cycle, strobe held for hold extra cycles while data keeps changing
	task automatic io_write(input logic [7:0] port, input logic [7:0] data, input int hold);
		start_cycle(8'h10, {8'h00, port});
		@(posedge clk_sys);
		bus.dout <= data;
		bus.wr_n <= 1'b0;
		for (int i = 0; i < hold; i++) begin
			@(posedge clk_sys);
			bus.dout <= rand_byte();
		end
		@(posedge clk_sys);
		bus.wr_n <= 1'b1;
		// Only the byte at the first strobe edge lands
		if (port == 8'h10) begin
			m_ed = data;
		end else if (port[7:1] == 7'h02) begin
			m_joy = joy_after(m_joy, port[0], data);
		end
	endtask

	task automatic drive_sticks();
		@(posedge clk_sys);
		joy_a <= rand_byte();
		joy_b <= rand_byte();
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial begin
		int         n;
		logic [7:0] d;
		cold_reset <= 1'b1;
		bus        <= '{addr: 16'h0000, dout: 8'h00, sync: 1'b0, rd: 1'b0, wr_n: 1'b1};
		joy_a      <= 8'h00;
		joy_b      <= 8'h00;
		mem_data   <= 8'h00;
		repeat (8) @(posedge clk_sys);
		cold_reset <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while ($isunknown({cpu_din, mem_req, mem_we, page}) && n < 16) begin
			@(negedge clk_sys);
			n++;
		end
		if (n == 16) begin
			$display("Timeout: DUT outputs stayed unknown after reset");
			$display("Checks failed");
		end else begin
			check("ram_page_o", {5'b0, page}, 8'h00);
			check("mem_req_o", {7'b0, mem_req}, {7'b0, mreq_of(m_status)});
			for (int i = 0; i < 12; i++) begin
				d = rand_byte();
				if (i < 2) begin
					d = {7'h02, i[0]};
				end
				bus_cycle(8'h42, {rand_byte(), d});
			end
			end_test("after reset");
			for (int i = 0; i < 16; i++) begin
				if (i % 4 == 0) begin
					bus_cycle(8'h23, {rand_byte(), rand_byte()});
				end else begin
					bus_cycle(mem_status(), {rand_byte(), rand_byte()});
				end
			end
			end_test("inta and memory");
			for (int i = 0; i < 8; i++) begin
				io_write(8'h10, rand_byte(), 0);
				repeat (12) bus_cycle(mem_status(), {rand_byte(), rand_byte()});
			end
			end_test("edisk paging");
			for (int i = 0; i < 16; i++) begin
				d = rand_byte();
				io_write({7'h02, d[0]}, rand_byte(), 0);
				drive_sticks();
				bus_cycle(8'h42, 16'h0006);
			end
			end_test("joystick writes");
			for (int i = 0; i < 16; i++) begin
				drive_sticks();
				bus_cycle(8'h42, 16'h000E);
				bus_cycle(8'h42, 16'h000F);
				bus_cycle(8'h42, 16'h0007);
			end
			end_test("stick views");
			// Stack enable forced so the stored bank shows on the page
			for (int i = 0; i < 4; i++) begin
				io_write(8'h10, rand_byte() | 8'h10, 3);
				repeat (4) bus_cycle(mem_status(), {rand_byte(), rand_byte()});
				io_write(8'h05, rand_byte(), 3);
				bus_cycle(8'h42, 16'h0006);
			end
			end_test("held strobe");
			$display("total %0d checks, %0d mismatches", checks, errors);
			if (errors == 0) begin
				$display("All checks passed");
			end else begin
				$display("Checks failed");
			end
		end
		$finish;
	end

endmodule

/* vec_io.f */
logic/vec_bus_pkg.sv
logic/vec_map_pkg.sv
logic/bus_status_latch.sv
logic/io_port_decoder.sv
logic/edisk_ctrl_reg.sv
logic/edisk_page_mapper.sv
logic/joystick_ports.sv
logic/vec_io_top.sv
bench/vec_io_model.sv
bench/vec_io_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = vec_io_tb
FILELIST = vec_io.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
